/* verilog/display_macros.svh */
// Fixed screen geometry and read latency; changing the size also needs the package widths changed
`ifndef DISPLAY_MACROS_SVH
`define DISPLAY_MACROS_SVH

// Visible screen size in pixels
`define DISPLAY_WIDTH 640
`define DISPLAY_HEIGHT 400

// Pixels per frame, width times height
`define DISPLAY_PIXELS 256000

// 32-bit words per frame buffer, 8 pixels each, rounded to a power of two
`define BUFFER_WORDS 32768

// Cycles from a scanner read address to its pixel at the top level
// Address register, RAM read, output register
`define READ_LATENCY 3

`endif

/* verilog/display_pkg.sv */
// Pixel and buffer types for a fixed 640x400 screen of 4-bit palette indices, 8 pixels per word
package display_pkg;

  // One palette index
  typedef logic [3:0] pixel_t;

  // Linear pixel index, row * 640 + column
  typedef logic [17:0] pixel_address_t;

  // Word index, pixel index without the lane bits
  typedef logic [14:0] word_address_t;

  // Nibble position within a storage word
  typedef logic [2:0] pixel_lane_t;

  typedef logic [31:0] buffer_word_t;

  // Buffer currently shown on the display
  typedef enum logic {
    BUFFER_A,
    BUFFER_B
  } buffer_select_t;

endpackage

/* verilog/scan_pkg.sv */
// Raster scanner types; column and row widths only cover the fixed 640x400 geometry
package scan_pkg;

  // Scanner FSM
  typedef enum logic {
    SCAN_IDLE,
    SCAN_ACTIVE
  } scan_state_t;

  // Column 0 to 639
  typedef logic [9:0] column_t;

  // Row 0 to 399
  typedef logic [8:0] row_t;

endpackage

/* verilog/display_buffer.sv */
// Single-port frame buffer; a write and a read share one address, the read returns the old word
`timescale 1ns/1ps

`include "display_macros.svh"

module display_buffer (
  input  logic                        clock_in,
  input  logic                        reset_n_in,
  input  display_pkg::pixel_address_t address,
  input  display_pkg::pixel_t         write_data,
  input  logic                        write_enable,
  output display_pkg::pixel_t         read_data
);

  display_pkg::buffer_word_t   memory [0:`BUFFER_WORDS-1];
  display_pkg::word_address_t  word_address;
  display_pkg::pixel_lane_t    lane;
  display_pkg::buffer_word_t   stored_word;
  display_pkg::buffer_word_t   merged_word;

  // Upper bits pick the word, low three bits pick the nibble
  assign word_address = display_pkg::word_address_t'(address >> 3);
  assign lane         = display_pkg::pixel_lane_t'(address);
  assign stored_word  = memory[word_address];

  // Replace one nibble and keep the other seven
  always_comb begin
    merged_word = stored_word;
    merged_word[{lane, 2'b00} +: 4] = write_data;
  end

  always_ff @(posedge clock_in) begin
    if (write_enable) begin
      memory[word_address] <= merged_word;
    end
  end

  // Registered nibble read, every cycle
  always_ff @(posedge clock_in) begin
    if (!reset_n_in) begin
      read_data <= '0;
    end else begin
      read_data <= stored_word[{lane, 2'b00} +: 4];
    end
  end

endmodule

/* verilog/display_buffers.sv */
// Double frame buffer; a switch waits for read address zero, so the swap always lands on pixel 0
`timescale 1ns/1ps

module display_buffers (
  input  logic                        clock_in,
  input  logic                        reset_n_in,
  input  logic                        pixel_write_enable,
  input  display_pkg::pixel_address_t pixel_write_address,
  input  display_pkg::pixel_t         pixel_write_data,
  input  display_pkg::pixel_address_t read_address,
  input  logic                        switch_request,
  output display_pkg::pixel_t         pixel_data,
  output logic                        switch_pending
);

  display_pkg::buffer_select_t displayed_buffer;
  display_pkg::buffer_select_t next_buffer;
  display_pkg::buffer_select_t output_select;
  logic [1:0]                  switch_monitor;
  logic                        swap_now;

  display_pkg::pixel_address_t address_a;
  display_pkg::pixel_address_t address_b;
  display_pkg::pixel_t         write_data_q;
  logic                        write_enable_a;
  logic                        write_enable_b;
  display_pkg::pixel_t         read_data_a;
  display_pkg::pixel_t         read_data_b;

  display_buffer buffer_a (
    .clock_in     (clock_in),
    .reset_n_in   (reset_n_in),
    .address      (address_a),
    .write_data   (write_data_q),
    .write_enable (write_enable_a),
    .read_data    (read_data_a)
  );

  display_buffer buffer_b (
    .clock_in     (clock_in),
    .reset_n_in   (reset_n_in),
    .address      (address_b),
    .write_data   (write_data_q),
    .write_enable (write_enable_b),
    .read_data    (read_data_b)
  );

  // Swap only at the start of a frame, or while the scanner idles at zero
  assign swap_now = switch_pending && (read_address == '0);

  // The new selection already steers the addresses registered on the swap edge
  assign next_buffer = !swap_now ? displayed_buffer :
                       (displayed_buffer == display_pkg::BUFFER_A) ? display_pkg::BUFFER_B :
                                                                     display_pkg::BUFFER_A;

  always_ff @(posedge clock_in) begin
    if (!reset_n_in) begin
      switch_monitor   <= 2'b00;
      switch_pending   <= 1'b0;
      displayed_buffer <= display_pkg::BUFFER_A;
      output_select    <= display_pkg::BUFFER_A;
    end else begin
      switch_monitor <= {switch_monitor[0], switch_request};
      // Rising edge of the request
      if (switch_monitor == 2'b01) begin
        switch_pending <= 1'b1;
      end
      if (swap_now) begin
        switch_pending <= 1'b0;
      end
      displayed_buffer <= next_buffer;
      // Two cycles behind the steering, matching the RAM read in flight
      output_select    <= displayed_buffer;
    end
  end

  // Front buffer gets the read address, back buffer the write request
  always_ff @(posedge clock_in) begin
    if (next_buffer == display_pkg::BUFFER_A) begin
      address_a <= read_address;
      address_b <= pixel_write_address;
    end else begin
      address_a <= pixel_write_address;
      address_b <= read_address;
    end
    write_data_q <= pixel_write_data;
  end

  // Enables travel with the write address
  always_ff @(posedge clock_in) begin
    if (!reset_n_in) begin
      write_enable_a <= 1'b0;
      write_enable_b <= 1'b0;
    end else begin
      write_enable_a <= pixel_write_enable && (next_buffer == display_pkg::BUFFER_B);
      write_enable_b <= pixel_write_enable && (next_buffer == display_pkg::BUFFER_A);
    end
  end

  // Output register
  always_ff @(posedge clock_in) begin
    if (!reset_n_in) begin
      pixel_data <= '0;
    end else if (output_select == display_pkg::BUFFER_A) begin
      pixel_data <= read_data_a;
    end else begin
      pixel_data <= read_data_b;
    end
  end

endmodule

/* verilog/display_scanner.sv */
// Raster scanner without blanking; stops only at a frame end, strobes delayed by the read latency
`timescale 1ns/1ps

`include "display_macros.svh"

module display_scanner (
  input  logic                        clock_in,
  input  logic                        reset_n_in,
  input  logic                        display_enable,
  output display_pkg::pixel_address_t read_address,
  output logic                        pixel_valid,
  output logic                        line_start,
  output logic                        frame_start,
  output scan_pkg::column_t           column,
  output scan_pkg::row_t              row
);

  scan_pkg::scan_state_t    state;
  scan_pkg::column_t        column_count;
  scan_pkg::row_t           row_count;
  logic                     active;
  logic                     last_column;
  logic                     last_row;
  logic                     last_pixel;

  logic [`READ_LATENCY-1:0] valid_pipe;
  logic [`READ_LATENCY-1:0] line_pipe;
  logic [`READ_LATENCY-1:0] frame_pipe;
  scan_pkg::column_t        column_pipe [`READ_LATENCY];
  scan_pkg::row_t           row_pipe [`READ_LATENCY];

  assign active      = (state == scan_pkg::SCAN_ACTIVE);
  assign last_column = (column_count == scan_pkg::column_t'(`DISPLAY_WIDTH - 1));
  assign last_row    = (row_count == scan_pkg::row_t'(`DISPLAY_HEIGHT - 1));
  assign last_pixel  = (read_address == display_pkg::pixel_address_t'(`DISPLAY_PIXELS - 1));

  // Counters sit at zero while idle
  always_ff @(posedge clock_in) begin
    if (!reset_n_in) begin
      state        <= scan_pkg::SCAN_IDLE;
      read_address <= '0;
      column_count <= '0;
      row_count    <= '0;
    end else begin
      case (state)
        scan_pkg::SCAN_IDLE: begin
          if (display_enable) begin
            state <= scan_pkg::SCAN_ACTIVE;
          end
        end
        scan_pkg::SCAN_ACTIVE: begin
          read_address <= last_pixel ? '0 : read_address + 1'b1;
          if (last_column) begin
            column_count <= '0;
            row_count    <= last_row ? '0 : row_count + 1'b1;
          end else begin
            column_count <= column_count + 1'b1;
          end
          // Finish the frame before going idle
          if (last_pixel && !display_enable) begin
            state <= scan_pkg::SCAN_IDLE;
          end
        end
        default: state <= scan_pkg::SCAN_IDLE;
      endcase
    end
  end

  // Strobe delay line
  always_ff @(posedge clock_in) begin
    if (!reset_n_in) begin
      valid_pipe <= '0;
      line_pipe  <= '0;
      frame_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[`READ_LATENCY-2:0], active};
      line_pipe  <= {line_pipe[`READ_LATENCY-2:0], active && (column_count == '0)};
      frame_pipe <= {frame_pipe[`READ_LATENCY-2:0], active && (read_address == '0)};
    end
  end

  // Coordinates follow the same delay
  always_ff @(posedge clock_in) begin
    column_pipe[0] <= column_count;
    row_pipe[0]    <= row_count;
    for (int i = 1; i < `READ_LATENCY; i++) begin
      column_pipe[i] <= column_pipe[i-1];
      row_pipe[i]    <= row_pipe[i-1];
    end
  end

  assign pixel_valid = valid_pipe[`READ_LATENCY-1];
  assign line_start  = line_pipe[`READ_LATENCY-1];
  assign frame_start = frame_pipe[`READ_LATENCY-1];
  assign column      = column_pipe[`READ_LATENCY-1];
  assign row         = row_pipe[`READ_LATENCY-1];

endmodule

/* verilog/display_top.sv */
// Frame store top; pixel_data and its strobes arrive three cycles after the read address
`timescale 1ns/1ps

module display_top (
  input  logic                        clock_in,
  input  logic                        reset_n_in,
  input  logic                        display_enable,
  input  logic                        pixel_write_enable,
  input  display_pkg::pixel_address_t pixel_write_address,
  input  display_pkg::pixel_t         pixel_write_data,
  input  logic                        switch_request,
  output display_pkg::pixel_t         pixel_data,
  output logic                        pixel_valid,
  output logic                        line_start,
  output logic                        frame_start,
  output scan_pkg::column_t           column,
  output scan_pkg::row_t              row,
  output logic                        switch_pending
);

  // Scanner address into the front buffer
  display_pkg::pixel_address_t read_address;

  display_scanner display_scanner_inst (
    .clock_in       (clock_in),
    .reset_n_in     (reset_n_in),
    .display_enable (display_enable),
    .read_address   (read_address),
    .pixel_valid    (pixel_valid),
    .line_start     (line_start),
    .frame_start    (frame_start),
    .column         (column),
    .row            (row)
  );

  display_buffers display_buffers_inst (
    .clock_in            (clock_in),
    .reset_n_in          (reset_n_in),
    .pixel_write_enable  (pixel_write_enable),
    .pixel_write_address (pixel_write_address),
    .pixel_write_data    (pixel_write_data),
    .read_address        (read_address),
    .switch_request      (switch_request),
    .pixel_data          (pixel_data),
    .switch_pending      (switch_pending)
  );

endmodule

/* bench/display_clock_gen.sv */
// Free-running 20 ns clock; reset is held low for 16 rising edges, released 2 ns after the last
`timescale 1ns/1ps

module display_clock_gen (
  output logic clock_in,
  output logic reset_n_in
);

  localparam int HALF_PERIOD_NS = 10;
  localparam int RESET_CYCLES = 16;

  initial begin
    clock_in = 1'b0;
    forever #(HALF_PERIOD_NS) clock_in = ~clock_in;
  end

  initial begin
    reset_n_in = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock_in);
    #2;
    reset_n_in = 1'b1;
  end

endmodule

/* bench/display_tb.sv */
// RAM contents start unknown, so only pixels the bench has written are compared; run is ~7 frames
`timescale 1ns/1ps

`include "display_macros.svh"

module display_tb;

  localparam longint WATCHDOG_NS = 64'd8 * `DISPLAY_PIXELS * 20 + 16 * 20;
  localparam int SWAP_LIMIT = `DISPLAY_PIXELS + 16;

  logic                        clock_in;
  logic                        reset_n_in;
  logic                        display_enable;
  logic                        pixel_write_enable;
  display_pkg::pixel_address_t pixel_write_address;
  display_pkg::pixel_t         pixel_write_data;
  logic                        switch_request;
  display_pkg::pixel_t         pixel_data;
  logic                        pixel_valid;
  logic                        line_start;
  logic                        frame_start;
  scan_pkg::column_t           column;
  scan_pkg::row_t              row;
  logic                        switch_pending;

  integer seed;
  int     monitor_errors = 0;
  int     sequence_errors = 0;
  logic   idle_check = 1'b0;

  // Reference model, one pixel array per buffer
  display_pkg::pixel_t model_pixels [2][`DISPLAY_PIXELS];
  bit                  model_known [2][`DISPLAY_PIXELS];
  int                  front_index = 0;
  int                  shown_front = 0;

  // Writes wait here until they are visible to a read
  logic                pipe_we [3] = '{1'b0, 1'b0, 1'b0};
  int                  pipe_buffer [3];
  int                  pipe_address [3];
  display_pkg::pixel_t pipe_data [3];

  scan_pkg::column_t exp_column = '0;
  scan_pkg::row_t    exp_row = '0;
  int   cycle_count = 0;
  int   pending_rise_cycle = 0;
  int   swap_count = 0;
  int   frame_count = 0;
  int   frame_valid_count = 0;
  int   pixels_checked = 0;
  int   pixel_index;
  logic pending_prev = 1'b0;
  logic valid_prev = 1'b0;

  display_clock_gen display_clock_gen_inst (
    .clock_in   (clock_in),
    .reset_n_in (reset_n_in)
  );

  display_top display_top_inst (
    .clock_in            (clock_in),
    .reset_n_in          (reset_n_in),
    .display_enable      (display_enable),
    .pixel_write_enable  (pixel_write_enable),
    .pixel_write_address (pixel_write_address),
    .pixel_write_data    (pixel_write_data),
    .switch_request      (switch_request),
    .pixel_data          (pixel_data),
    .pixel_valid         (pixel_valid),
    .line_start          (line_start),
    .frame_start         (frame_start),
    .column              (column),
    .row                 (row),
    .switch_pending      (switch_pending)
  );

  task automatic report_mismatch(input string name, input int unsigned expected,
                                 input int unsigned actual);
    $display("error %s expected %h actual %h", name, expected, actual);
  endtask

  // Front flips on the edge where switch_pending falls
  task automatic track_switch();
    if (switch_pending && !pending_prev) begin
      pending_rise_cycle = cycle_count;
    end
    if (!switch_pending && pending_prev) begin
      front_index = 1 - front_index;
      swap_count++;
      if (cycle_count - pending_rise_cycle > `DISPLAY_PIXELS + 2) begin
        $display("switch_pending stayed high for %0d cycles, more than one frame",
                 cycle_count - pending_rise_cycle);
        monitor_errors++;
      end
    end
    if (idle_check && (switch_pending !== 1'b0)) begin
      report_mismatch("switch_pending", 0, 32'(switch_pending));
      monitor_errors++;
    end
    pending_prev = switch_pending;
  endtask

  task automatic check_raster();
    logic expect_line;
    logic expect_frame;
    expect_line  = (exp_column == '0);
    expect_frame = expect_line && (exp_row == '0);
    if (idle_check && (pixel_valid !== 1'b0)) begin
      report_mismatch("pixel_valid", 0, 32'(pixel_valid));
      monitor_errors++;
    end
    if (pixel_valid === 1'b1) begin
      if (column !== exp_column) begin
        report_mismatch("column", 32'(exp_column), 32'(column));
        monitor_errors++;
      end
      if (row !== exp_row) begin
        report_mismatch("row", 32'(exp_row), 32'(row));
        monitor_errors++;
      end
      if (line_start !== expect_line) begin
        report_mismatch("line_start", 32'(expect_line), 32'(line_start));
        monitor_errors++;
      end
      if (frame_start !== expect_frame) begin
        report_mismatch("frame_start", 32'(expect_frame), 32'(frame_start));
        monitor_errors++;
      end
      if (frame_start === 1'b1) begin
        if (frame_count > 0 && frame_valid_count != `DISPLAY_PIXELS) begin
          $display("frame_start came after %0d valid cycles", frame_valid_count);
          monitor_errors++;
        end
        frame_valid_count = 0;
        frame_count++;
      end
      if (expect_frame) begin
        shown_front = front_index;
      end
      frame_valid_count++;
      pixel_index = int'(exp_row) * `DISPLAY_WIDTH + int'(exp_column);
      if (model_known[shown_front][pixel_index]) begin
        pixels_checked++;
        if (pixel_data !== model_pixels[shown_front][pixel_index]) begin
          report_mismatch("pixel_data", 32'(model_pixels[shown_front][pixel_index]),
                          32'(pixel_data));
          monitor_errors++;
        end
      end
      // Raster order, wrapping at the end of each line and frame
      if (exp_column == scan_pkg::column_t'(`DISPLAY_WIDTH - 1)) begin
        exp_column = '0;
        exp_row = (exp_row == scan_pkg::row_t'(`DISPLAY_HEIGHT - 1)) ? '0 : exp_row + 1'b1;
      end else begin
        exp_column = exp_column + 1'b1;
      end
    end else begin
      if (line_start !== 1'b0 || frame_start !== 1'b0) begin
        $display("line_start or frame_start pulsed without pixel_valid");
        monitor_errors++;
      end
      if (valid_prev && !expect_frame) begin
        $display("pixel_valid dropped in the middle of a frame");
        monitor_errors++;
      end
    end
    valid_prev = pixel_valid;
  endtask

  // Monitor samples 1 ns after the edge, inputs still hold their edge values
  always begin
    @(posedge clock_in);
    #1;
    cycle_count++;
    if (reset_n_in) begin
      track_switch();
      if (pipe_we[2]) begin
        model_pixels[pipe_buffer[2]][pipe_address[2]] = pipe_data[2];
        model_known[pipe_buffer[2]][pipe_address[2]] = 1'b1;
      end
      check_raster();
    end
    for (int i = 2; i > 0; i--) begin
      pipe_we[i]      = pipe_we[i-1];
      pipe_buffer[i]  = pipe_buffer[i-1];
      pipe_address[i] = pipe_address[i-1];
      pipe_data[i]    = pipe_data[i-1];
    end
    pipe_we[0]      = reset_n_in && pixel_write_enable;
    pipe_buffer[0]  = 1 - front_index;
    pipe_address[0] = int'(pixel_write_address);
    pipe_data[0]    = pixel_write_data;
  end

  task automatic next_cycle();
    @(posedge clock_in);
    #2;
  endtask

  task automatic write_full_frame();
    for (int i = 0; i < `DISPLAY_PIXELS; i++) begin
      pixel_write_enable  = 1'b1;
      pixel_write_address = display_pkg::pixel_address_t'(i);
      pixel_write_data    = display_pkg::pixel_t'($random(seed));
      next_cycle();
    end
    pixel_write_enable = 1'b0;
  endtask

  // About one write in four cycles, random addresses
  task automatic write_sparse(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      pixel_write_enable  = (($random(seed) & 3) == 0);
      pixel_write_address =
        display_pkg::pixel_address_t'($unsigned($random(seed)) % `DISPLAY_PIXELS);
      pixel_write_data    = display_pkg::pixel_t'($random(seed));
      next_cycle();
    end
    pixel_write_enable = 1'b0;
  endtask

  task automatic wait_for_swap(input int limit, input string what);
    int start_count;
    int cycles;
    start_count = swap_count;
    cycles = 0;
    while (swap_count == start_count && cycles < limit) begin
      next_cycle();
      cycles++;
    end
    if (swap_count == start_count) begin
      $display("%s: no buffer swap within %0d cycles", what, limit);
      sequence_errors++;
    end
  endtask

  task automatic wait_for_frame_start(input int limit);
    int start_count;
    int cycles;
    start_count = frame_count;
    cycles = 0;
    while (frame_count == start_count && cycles < limit) begin
      next_cycle();
      cycles++;
    end
    if (frame_count == start_count) begin
      $display("no frame_start within %0d cycles", limit);
      sequence_errors++;
    end
  endtask

  task automatic check_coverage(input int start_checked);
    if (pixels_checked - start_checked != `DISPLAY_PIXELS) begin
      $display("frame check covered %0d pixels instead of a full frame",
               pixels_checked - start_checked);
      sequence_errors++;
    end
  endtask

  initial begin
    int swaps;
    int checked_start;
    int frames;
    int cycles;
    seed = 32'h3294;
    display_enable      = 1'b0;
    pixel_write_enable  = 1'b0;
    pixel_write_address = '0;
    pixel_write_data    = '0;
    switch_request      = 1'b0;
    wait (reset_n_in === 1'b1);
    next_cycle();
    if (pixel_data !== '0) begin
      report_mismatch("pixel_data", 0, 32'(pixel_data));
      sequence_errors++;
    end
    idle_check = 1'b1;
    repeat (100) next_cycle();
    idle_check = 1'b0;

    // Fill buffer B behind the displayed A, then switch and hold the request
    display_enable = 1'b1;
    write_full_frame();
    swaps = swap_count;
    switch_request = 1'b1;
    wait_for_swap(SWAP_LIMIT, "first switch");
    wait_for_frame_start(16);
    checked_start = pixels_checked;
    frames = frame_count;
    write_full_frame();
    // The full write lasts one frame, so the next frame_start may already be past
    if (frame_count == frames) begin
      wait_for_frame_start(SWAP_LIMIT);
    end
    check_coverage(checked_start);
    if (swap_count != swaps + 1) begin
      $display("held switch_request gave %0d swaps instead of one", swap_count - swaps);
      sequence_errors++;
    end
    switch_request = 1'b0;
    write_sparse(`DISPLAY_PIXELS / 2);

    // Two request edges, kept well away from the frame end
    cycles = 0;
    while (!(pixel_valid && int'(row) > 0 && int'(row) < 390) && cycles < SWAP_LIMIT) begin
      next_cycle();
      cycles++;
    end
    swaps = swap_count;
    switch_request = 1'b1;
    repeat (3) next_cycle();
    switch_request = 1'b0;
    repeat (3) next_cycle();
    switch_request = 1'b1;
    repeat (3) next_cycle();
    switch_request = 1'b0;
    wait_for_swap(SWAP_LIMIT, "double edge switch");
    // A second swap could only come at the next frame start
    wait_for_frame_start(16);
    wait_for_frame_start(SWAP_LIMIT);
    if (swap_count != swaps + 1) begin
      $display("two request edges gave %0d swaps instead of one", swap_count - swaps);
      sequence_errors++;
    end

    // Stop at the frame end, switch while idle, restart
    display_enable = 1'b0;
    cycles = 0;
    while (pixel_valid && cycles < SWAP_LIMIT) begin
      next_cycle();
      cycles++;
    end
    if (pixel_valid) begin
      $display("scanner did not stop at the end of the frame");
      sequence_errors++;
    end
    repeat (20) next_cycle();
    switch_request = 1'b1;
    wait_for_swap(16, "idle switch");
    switch_request = 1'b0;
    display_enable = 1'b1;
    wait_for_frame_start(16);
    checked_start = pixels_checked;
    wait_for_frame_start(SWAP_LIMIT);
    check_coverage(checked_start);

    $display("Run complete: %0d monitor errors, %0d sequence errors, %0d pixels checked",
             monitor_errors, sequence_errors, pixels_checked);
    if (monitor_errors + sequence_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: run still busy after %0d ns, %0d errors so far",
             WATCHDOG_NS, monitor_errors + sequence_errors);
    $display("Errors found");
    $finish;
  end

endmodule

/* project.f */
+incdir+verilog
verilog/display_pkg.sv
verilog/scan_pkg.sv
verilog/display_buffer.sv
verilog/display_buffers.sv
verilog/display_scanner.sv
verilog/display_top.sv
bench/display_clock_gen.sv
bench/display_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the frame store testbench with Verilator.
# Exits non-zero when the build fails, the run fails or the log reports errors.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=display_tb_sim
LOG_FILE=sim.log

verilator --binary --timing -j 0 \
  -f project.f \
  --top-module display_tb \
  -Mdir "$BUILD_DIR" \
  -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Errors found" "$LOG_FILE"; then
  echo "FAIL"
  exit 1
fi

echo "PASS"
exit 0
